// File: source/dccm_pkg.sv
//~~~~~~~~~~~~~~~~~~~~
// DCCM geometry: 8 banks of 39-bit words behind a 16-bit byte address
// Bank and index fields are derived, only the base widths are free
//~~~~~~~~~~~~~~~~~~~~

package dccm_pkg;

   // Byte address seen by the load/store pipe
   localparam int DCCM_ADDR_WIDTH = 16;

   // 32 data bits plus 7 check bits, stored as given
   localparam int DCCM_DATA_WIDTH = 39;

   // Byte within a 32-bit word, ignored by the memory
   localparam int DCCM_BYTE_BITS = 2;

   // Bank select field sits just above the byte offset
   localparam int DCCM_BANK_BITS = 3;
   localparam int DCCM_BANK_LSB = DCCM_BYTE_BITS;
   localparam int DCCM_NUM_BANKS = 1 << DCCM_BANK_BITS;

   // Everything above the bank field indexes a word inside the bank
   localparam int DCCM_INDEX_LSB = DCCM_BANK_LSB + DCCM_BANK_BITS;
   localparam int DCCM_INDEX_BITS = DCCM_ADDR_WIDTH - DCCM_INDEX_LSB;
   localparam int DCCM_DEPTH = 1 << DCCM_INDEX_BITS;

endpackage

// File: source/dccm_bank_if.sv
//~~~~~~~~~~~~~~~~~~~~
// Per-bank request lines from the decoder to the eight RAM banks
// Each bank reads only its own entry of every array
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

interface dccm_bank_if;
   import dccm_pkg::*;

   // Memory enable, high for any access that touches the bank
   logic [DCCM_NUM_BANKS-1:0] bank_en;

   // Write strobe, only meaningful with bank_en
   logic [DCCM_NUM_BANKS-1:0] bank_we;

   // Word index within the bank
   logic [DCCM_NUM_BANKS-1:0][DCCM_INDEX_BITS-1:0] bank_index;

   // Word to store, check bits included
   logic [DCCM_NUM_BANKS-1:0][DCCM_DATA_WIDTH-1:0] bank_wdata;

   modport decoder (
      output bank_en,
      output bank_we,
      output bank_index,
      output bank_wdata
   );

   modport bank (
      input bank_en,
      input bank_we,
      input bank_index,
      input bank_wdata
   );

endinterface

// File: source/dccm_bank_decode.sv
//~~~~~~~~~~~~~~~~~~~~
// Steers one read or write per cycle onto one or two adjacent banks
// Caller must keep the high address equal to the low one or the next word
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module dccm_bank_decode (
   input  logic                                 clk,
   input  logic                                 wren,
   input  logic                                 rden,
   input  logic [dccm_pkg::DCCM_ADDR_WIDTH-1:0] wr_addr_lo,
   input  logic [dccm_pkg::DCCM_ADDR_WIDTH-1:0] wr_addr_hi,
   input  logic [dccm_pkg::DCCM_ADDR_WIDTH-1:0] rd_addr_lo,
   input  logic [dccm_pkg::DCCM_ADDR_WIDTH-1:0] rd_addr_hi,
   input  logic [dccm_pkg::DCCM_DATA_WIDTH-1:0] wr_data_lo,
   input  logic [dccm_pkg::DCCM_DATA_WIDTH-1:0] wr_data_hi,
   dccm_bank_if.decoder                         banks
);
   import dccm_pkg::*;

   localparam int WORD_BITS = DCCM_ADDR_WIDTH - DCCM_BANK_LSB;

   logic [DCCM_ADDR_WIDTH-1:0] addr_lo;
   logic [DCCM_ADDR_WIDTH-1:0] addr_hi;
   logic [DCCM_BANK_BITS-1:0]  bank_lo;
   logic [DCCM_BANK_BITS-1:0]  bank_hi;
   logic [DCCM_INDEX_BITS-1:0] index_lo;
   logic [DCCM_INDEX_BITS-1:0] index_hi;
   logic                       misaligned;
   logic [WORD_BITS-1:0]       word_lo;
   logic [WORD_BITS-1:0]       word_hi;

   // Read addresses win whenever rden is up
   assign addr_lo = rden ? rd_addr_lo : wr_addr_lo;
   assign addr_hi = rden ? rd_addr_hi : wr_addr_hi;

   assign bank_lo  = addr_lo[DCCM_BANK_LSB +: DCCM_BANK_BITS];
   assign bank_hi  = addr_hi[DCCM_BANK_LSB +: DCCM_BANK_BITS];
   assign index_lo = addr_lo[DCCM_INDEX_LSB +: DCCM_INDEX_BITS];
   assign index_hi = addr_hi[DCCM_INDEX_LSB +: DCCM_INDEX_BITS];

   // Two banks in play only when the halves land in different banks
   assign misaligned = (bank_lo != bank_hi);

   // Word addresses, byte offset dropped
   assign word_lo = addr_lo[DCCM_BANK_LSB +: WORD_BITS];
   assign word_hi = addr_hi[DCCM_BANK_LSB +: WORD_BITS];

   always_comb begin
      logic hit_lo;
      logic hit_hi;
      logic take_hi;
      for (int i = 0; i < DCCM_NUM_BANKS; i++) begin
         hit_lo  = (bank_lo == DCCM_BANK_BITS'(i));
         hit_hi  = (bank_hi == DCCM_BANK_BITS'(i));
         take_hi = hit_hi & misaligned;

         // Enable doubles as the bank clock gate
         banks.bank_en[i] = (wren | rden) & (hit_lo | hit_hi);
         banks.bank_we[i] = wren & (hit_lo | hit_hi);

         banks.bank_index[i] = take_hi ? index_hi : index_lo;
         banks.bank_wdata[i] = take_hi ? wr_data_hi : wr_data_lo;
      end
   end

   // One port per bank, so a read and a write cannot share a cycle
   a_no_rd_wr_overlap : assert property (
      @(posedge clk) !(wren && rden)
   ) else $error("dccm: wren and rden high together");

   // High half is the same word or the next one, including the 7 to 0 wrap
   a_hi_addr_adjacent : assert property (
      @(posedge clk) (wren || rden) |->
         ((word_hi == word_lo) || (word_hi == word_lo + WORD_BITS'(1)))
   ) else $error("dccm: high address %h not adjacent to low address %h",
                 addr_hi, addr_lo);

endmodule

// File: source/dccm_bank_ram.sv
//~~~~~~~~~~~~~~~~~~~~
// Behavioral single-port bank with a registered read word
// DEPTH must not exceed the index range carried by the bank interface
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module dccm_bank_ram #(
   parameter int DEPTH = 2048,
   parameter int WIDTH = 39
) (
   input  logic                                clk,
   dccm_bank_if.bank                           bank,
   input  logic [dccm_pkg::DCCM_BANK_BITS-1:0] bank_id,
   output logic [WIDTH-1:0]                    dout
);

   logic [WIDTH-1:0] mem [DEPTH];

   logic             en;
   logic             we;
   logic [WIDTH-1:0] wdata;

   // Own slot of the shared request arrays
   assign en    = bank.bank_en[bank_id];
   assign we    = bank.bank_we[bank_id];
   assign wdata = bank.bank_wdata[bank_id];

   // Contents and read word are left uninitialized
   always_ff @(posedge clk) begin
      if (en) begin
         if (we) begin
            mem[bank.bank_index[bank_id]] <= wdata;
         end else begin
            dout <= mem[bank.bank_index[bank_id]];
         end
      end
   end

   // A write leaves dout alone, so the last read word stays visible

endmodule

// File: source/dccm_read_mux.sv
//~~~~~~~~~~~~~~~~~~~~
// Second read stage: captures bank words, then picks low and high words
// Data lands two cycles after rden and holds until the next read
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module dccm_read_mux (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                rden,
   input  logic [dccm_pkg::DCCM_BANK_BITS-1:0] rd_bank_lo,
   input  logic [dccm_pkg::DCCM_BANK_BITS-1:0] rd_bank_hi,
   input  logic [dccm_pkg::DCCM_NUM_BANKS-1:0][dccm_pkg::DCCM_DATA_WIDTH-1:0] bank_dout,
   output logic [dccm_pkg::DCCM_DATA_WIDTH-1:0] rd_data_lo,
   output logic [dccm_pkg::DCCM_DATA_WIDTH-1:0] rd_data_hi
);
   import dccm_pkg::*;

   logic                                            rden_q;
   logic [DCCM_BANK_BITS-1:0]                       bank_lo_q;
   logic [DCCM_BANK_BITS-1:0]                       bank_hi_q;
   logic [DCCM_BANK_BITS-1:0]                       bank_lo_q2;
   logic [DCCM_BANK_BITS-1:0]                       bank_hi_q2;
   logic [DCCM_NUM_BANKS-1:0][DCCM_DATA_WIDTH-1:0]  bank_dout_q;

   // Stage 1: bank outputs are being registered inside the RAMs
   always_ff @(posedge clk) begin
      if (reset) begin
         rden_q    <= 1'b0;
         bank_lo_q <= '0;
         bank_hi_q <= '0;
      end else begin
         rden_q <= rden;
         // Bank fields only move with a read, so idle cycles keep the select
         if (rden) begin
            bank_lo_q <= rd_bank_lo;
            bank_hi_q <= rd_bank_hi;
         end
      end
   end

   // Stage 2: capture every bank word alongside its select
   always_ff @(posedge clk) begin
      if (reset) begin
         bank_lo_q2  <= '0;
         bank_hi_q2  <= '0;
         bank_dout_q <= '0;
      end else if (rden_q) begin
         bank_lo_q2  <= bank_lo_q;
         bank_hi_q2  <= bank_hi_q;
         bank_dout_q <= bank_dout;
      end
   end

   // Load-to-use +1 path, the select is purely combinational
   assign rd_data_lo = bank_dout_q[bank_lo_q2];
   assign rd_data_hi = bank_dout_q[bank_hi_q2];

   // A known read address two stages back must reach the capture point
   a_sel_known : assert property (
      @(posedge clk) disable iff (reset)
         rden_q |-> !$isunknown({bank_lo_q, bank_hi_q})
   ) else $error("dccm: unknown read bank select at capture");

endmodule

// File: source/dccm_mem.sv
//~~~~~~~~~~~~~~~~~~~~
// DCCM top: decoder, eight single-port banks and the read select stage
// Check bits pass through untouched, no ECC is done here
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module dccm_mem (
   input  logic                                 clk,
   input  logic                                 reset,

   input  logic                                 wren,
   input  logic                                 rden,
   input  logic [dccm_pkg::DCCM_ADDR_WIDTH-1:0] wr_addr_lo,
   input  logic [dccm_pkg::DCCM_ADDR_WIDTH-1:0] wr_addr_hi,
   input  logic [dccm_pkg::DCCM_ADDR_WIDTH-1:0] rd_addr_lo,
   // Next word for a misaligned read, else same as rd_addr_lo
   input  logic [dccm_pkg::DCCM_ADDR_WIDTH-1:0] rd_addr_hi,
   input  logic [dccm_pkg::DCCM_DATA_WIDTH-1:0] wr_data_lo,
   input  logic [dccm_pkg::DCCM_DATA_WIDTH-1:0] wr_data_hi,

   output logic [dccm_pkg::DCCM_DATA_WIDTH-1:0] rd_data_lo,
   output logic [dccm_pkg::DCCM_DATA_WIDTH-1:0] rd_data_hi
);
   import dccm_pkg::*;

   dccm_bank_if banks ();

   logic [DCCM_NUM_BANKS-1:0][DCCM_DATA_WIDTH-1:0] bank_dout;

   dccm_bank_decode decode_i (
      .clk        (clk),
      .wren       (wren),
      .rden       (rden),
      .wr_addr_lo (wr_addr_lo),
      .wr_addr_hi (wr_addr_hi),
      .rd_addr_lo (rd_addr_lo),
      .rd_addr_hi (rd_addr_hi),
      .wr_data_lo (wr_data_lo),
      .wr_data_hi (wr_data_hi),
      .banks      (banks.decoder)
   );

   // 8 banks of 2048 x 39
   for (genvar i = 0; i < DCCM_NUM_BANKS; i++) begin : g_bank
      dccm_bank_ram #(
         .DEPTH (DCCM_DEPTH),
         .WIDTH (DCCM_DATA_WIDTH)
      ) ram_i (
         .clk     (clk),
         .bank    (banks.bank),
         .bank_id (DCCM_BANK_BITS'(i)),
         .dout    (bank_dout[i])
      );
   end

   dccm_read_mux read_mux_i (
      .clk        (clk),
      .reset      (reset),
      .rden       (rden),
      .rd_bank_lo (rd_addr_lo[DCCM_BANK_LSB +: DCCM_BANK_BITS]),
      .rd_bank_hi (rd_addr_hi[DCCM_BANK_LSB +: DCCM_BANK_BITS]),
      .bank_dout  (bank_dout),
      .rd_data_lo (rd_data_lo),
      .rd_data_hi (rd_data_hi)
   );

endmodule

// File: include/tb_dccm_tasks.svh
//~~~~~~~~~~~~~~~~~~~~
// Test tasks and word-address reference model for the DCCM testbench
// Every task starts and ends just after a falling clock edge
//~~~~~~~~~~~~~~~~~~~~

`ifndef TB_DCCM_TASKS_SVH
`define TB_DCCM_TASKS_SVH

   // Cycle budget of each test for the watchdog
   localparam int ALIGNED_CYCLES      = 2 * DCCM_NUM_BANKS * 3 + 2;
   localparam int MISALIGNED_CYCLES   = 4 * 6 + 2;
   localparam int WRAP_CYCLES         = 2 * 5 + 2;
   localparam int BACK_TO_BACK_CYCLES = DCCM_NUM_BANKS + 16 + 2;
   localparam int HOLD_CYCLES         = 18 + RESET_CYCLES;

   // Reference contents keyed by word address
   data_t model [word_t];

   // Expected words of the reads in flight
   // Entry 0 was issued one cycle ago and entry 1 two cycles ago
   logic  pend_valid [2];
   data_t pend_lo    [2];
   data_t pend_hi    [2];

   // What rd_data must show between reads
   data_t held_lo;
   data_t held_hi;

   function automatic word_t make_word(input logic [DCCM_INDEX_BITS-1:0] index,
                                       input logic [DCCM_BANK_BITS-1:0] bank);
      return {index, bank};
   endfunction

   // Random byte offset that the memory ignores
   function automatic logic [DCCM_ADDR_WIDTH-1:0] word_to_addr(input word_t word);
      return {word, DCCM_BYTE_BITS'($urandom())};
   endfunction

   function automatic data_t random_word();
      logic [63:0] bits;
      bits = {$urandom(), $urandom()};
      return bits[DCCM_DATA_WIDTH-1:0];
   endfunction

   function automatic void compare_outputs(input data_t exp_lo, input data_t exp_hi,
                                           input string what);
      check_count++;
      if (rd_data_lo !== exp_lo || rd_data_hi !== exp_hi) begin
         fail_count++;
         $display("ERROR at %0t ns: %s, %s: expected lo %h hi %h, got lo %h hi %h",
                  $time, cur_test, what, exp_lo, exp_hi, rd_data_lo, rd_data_hi);
      end
   endfunction

   // Advance one clock and check the read issued two cycles ago
   task automatic next_cycle(input logic rd_valid, input data_t rd_lo, input data_t rd_hi);
      @(negedge clk);
      pend_valid[1] = pend_valid[0];
      pend_lo[1]    = pend_lo[0];
      pend_hi[1]    = pend_hi[0];
      pend_valid[0] = rd_valid;
      pend_lo[0]    = rd_lo;
      pend_hi[0]    = rd_hi;
      if (pend_valid[1]) begin
         held_lo = pend_lo[1];
         held_hi = pend_hi[1];
      end
      compare_outputs(held_lo, held_hi, "read data");
   endtask

   task automatic idle(input int cycles);
      wren = 1'b0;
      rden = 1'b0;
      repeat (cycles) begin
         next_cycle(1'b0, '0, '0);
      end
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      wren  = 1'b0;
      rden  = 1'b0;
      pend_valid[0] = 1'b0;
      pend_valid[1] = 1'b0;
      held_lo    = '0;
      held_hi    = '0;
      repeat (RESET_CYCLES) begin
         next_cycle(1'b0, '0, '0);
      end
      reset = 1'b0;
   endtask

   task automatic write_pair(input word_t word_lo, input logic misaligned,
                             input data_t data_lo, input data_t data_hi);
      word_t word_hi;
      word_hi    = misaligned ? word_lo + WORD_BITS'(1) : word_lo;
      wren       = 1'b1;
      rden       = 1'b0;
      wr_addr_lo = word_to_addr(word_lo);
      wr_addr_hi = word_to_addr(word_hi);
      wr_data_lo = data_lo;
      wr_data_hi = misaligned ? data_hi : data_lo;
      model[word_lo] = data_lo;
      if (misaligned) begin
         model[word_hi] = data_hi;
      end
      next_cycle(1'b0, '0, '0);
      wren = 1'b0;
   endtask

   task automatic read_pair(input word_t word_lo, input logic misaligned);
      word_t word_hi;
      word_hi    = misaligned ? word_lo + WORD_BITS'(1) : word_lo;
      wren       = 1'b0;
      rden       = 1'b1;
      rd_addr_lo = word_to_addr(word_lo);
      rd_addr_hi = word_to_addr(word_hi);
      next_cycle(1'b1, model[word_lo], model[word_hi]);
      rden = 1'b0;
   endtask

   function automatic void report_test(input int fails_before);
      $display("%s finished, %0d errors", cur_test, fail_count - fails_before);
   endfunction

   task automatic aligned_round_trip();
      word_t                      words [$];
      logic [DCCM_INDEX_BITS-1:0] indexes [3];
      word_t                      w;
      data_t                      d;
      int                         fails_before;
      fails_before = fail_count;
      cur_test     = "aligned round trip";
      indexes[0]   = '0;
      indexes[1]   = DCCM_INDEX_BITS'($urandom());
      indexes[2]   = '1;
      for (int b = 0; b < DCCM_NUM_BANKS; b++) begin
         for (int k = 0; k < 3; k++) begin
            w = make_word(indexes[k], DCCM_BANK_BITS'(b));
            words.push_back(w);
            d = random_word();
            write_pair(w, 1'b0, d, d);
         end
      end
      foreach (words[i]) begin
         read_pair(words[i], 1'b0);
      end
      idle(2);
      report_test(fails_before);
   endtask

   task automatic misaligned_access();
      word_t w;
      data_t d_lo;
      data_t d_hi;
      int    fails_before;
      fails_before = fail_count;
      cur_test     = "misaligned access";
      repeat (4) begin
         // Low bank stays below 7 and both halves share one index
         w = make_word(DCCM_INDEX_BITS'($urandom()), DCCM_BANK_BITS'($urandom_range(6, 0)));
         d_lo = random_word();
         write_pair(w - WORD_BITS'(1), 1'b0, d_lo, d_lo);
         d_lo = random_word();
         write_pair(w + WORD_BITS'(2), 1'b0, d_lo, d_lo);
         d_lo = random_word();
         d_hi = random_word();
         write_pair(w, 1'b1, d_lo, d_hi);
         read_pair(w, 1'b1);
         read_pair(w - WORD_BITS'(1), 1'b0);
         read_pair(w + WORD_BITS'(2), 1'b0);
      end
      idle(2);
      report_test(fails_before);
   endtask

   task automatic bank_wrap();
      logic [DCCM_INDEX_BITS-1:0] index;
      word_t                      w;
      data_t                      d_lo;
      data_t                      d_hi;
      int                         fails_before;
      fails_before = fail_count;
      cur_test     = "bank 7 to bank 0 wrap";
      repeat (2) begin
         index = DCCM_INDEX_BITS'($urandom_range(DCCM_DEPTH - 2, 0));
         w     = make_word(index, DCCM_BANK_BITS'(7));
         // Same index in bank 0 must stay untouched
         d_lo = random_word();
         write_pair(make_word(index, '0), 1'b0, d_lo, d_lo);
         d_lo = random_word();
         d_hi = random_word();
         write_pair(w, 1'b1, d_lo, d_hi);
         read_pair(w, 1'b1);
         read_pair(make_word(index + DCCM_INDEX_BITS'(1), '0), 1'b0);
         read_pair(make_word(index, '0), 1'b0);
      end
      idle(2);
      report_test(fails_before);
   endtask

   task automatic back_to_back_reads();
      word_t words [$];
      word_t w;
      data_t d;
      int    fails_before;
      fails_before = fail_count;
      cur_test     = "back-to-back reads";
      for (int b = 0; b < DCCM_NUM_BANKS; b++) begin
         w = make_word(DCCM_INDEX_BITS'($urandom()), DCCM_BANK_BITS'(b));
         words.push_back(w);
         d = random_word();
         write_pair(w, 1'b0, d, d);
      end
      // One read per cycle keeps two in flight
      foreach (words[i]) begin
         read_pair(words[i], 1'b0);
      end
      repeat (8) begin
         read_pair(words[$urandom_range(DCCM_NUM_BANKS - 1, 0)], 1'b0);
      end
      idle(2);
      report_test(fails_before);
   endtask

   task automatic hold_and_reset();
      word_t w;
      data_t d1;
      data_t d2;
      data_t d;
      int    fails_before;
      fails_before = fail_count;
      cur_test     = "hold and reset";
      w  = make_word(DCCM_INDEX_BITS'($urandom()), DCCM_BANK_BITS'($urandom()));
      d1 = random_word();
      d2 = random_word();
      write_pair(w, 1'b0, d1, d1);
      read_pair(w, 1'b0);
      idle(5);
      write_pair(w, 1'b0, d2, d2);
      d = random_word();
      write_pair(w + WORD_BITS'(1), 1'b0, d, d);
      d = random_word();
      write_pair(w + WORD_BITS'(9), 1'b0, d, d);
      idle(2);
      compare_outputs(d1, d1, "held after idle and write cycles");
      apply_reset();
      compare_outputs('0, '0, "outputs after reset");
      // Bank contents survive reset
      read_pair(w, 1'b0);
      idle(2);
      compare_outputs(d2, d2, "read after reset");
      report_test(fails_before);
   endtask

`endif

// File: test/tb_dccm_mem.sv
//~~~~~~~~~~~~~~~~~~~~
// Directed testbench for dccm_mem, read data compared on every cycle
// Only words written earlier in the run are ever read back
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module tb_dccm_mem;
   import dccm_pkg::*;

   localparam int          CLK_PERIOD   = 40;
   localparam int          RESET_CYCLES = 3;
   localparam logic [31:0] RANDOM_SEED  = 32'hcee0_349c;

   // Word address, byte offset dropped
   localparam int WORD_BITS = DCCM_ADDR_WIDTH - DCCM_BANK_LSB;

   typedef logic [DCCM_DATA_WIDTH-1:0] data_t;
   typedef logic [WORD_BITS-1:0]       word_t;

   logic                       clk = 1'b0;
   logic                       reset;
   logic                       wren;
   logic                       rden;
   logic [DCCM_ADDR_WIDTH-1:0] wr_addr_lo;
   logic [DCCM_ADDR_WIDTH-1:0] wr_addr_hi;
   logic [DCCM_ADDR_WIDTH-1:0] rd_addr_lo;
   logic [DCCM_ADDR_WIDTH-1:0] rd_addr_hi;
   data_t                      wr_data_lo;
   data_t                      wr_data_hi;
   data_t                      rd_data_lo;
   data_t                      rd_data_hi;

   int    check_count;
   int    fail_count;
   string cur_test;

   dccm_mem dut_i (
      .clk        (clk),
      .reset      (reset),
      .wren       (wren),
      .rden       (rden),
      .wr_addr_lo (wr_addr_lo),
      .wr_addr_hi (wr_addr_hi),
      .rd_addr_lo (rd_addr_lo),
      .rd_addr_hi (rd_addr_hi),
      .wr_data_lo (wr_data_lo),
      .wr_data_hi (wr_data_hi),
      .rd_data_lo (rd_data_lo),
      .rd_data_hi (rd_data_hi)
   );

   `include "tb_dccm_tasks.svh"

   localparam int TOTAL_CYCLES = RESET_CYCLES + ALIGNED_CYCLES + MISALIGNED_CYCLES
                                 + WRAP_CYCLES + BACK_TO_BACK_CYCLES + HOLD_CYCLES;

   // Twice the planned run length
   localparam int WATCHDOG_NS = TOTAL_CYCLES * CLK_PERIOD * 2;

   initial begin
      forever begin
         #(CLK_PERIOD / 2);
         clk = ~clk;
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired at %0t ns, the tests did not finish in time", $time);
      $display("Checks failed");
      $finish;
   end

   initial begin
      void'($urandom(RANDOM_SEED));
      check_count = 0;
      fail_count  = 0;
      cur_test    = "power-on reset";
      reset       = 1'b1;
      wren        = 1'b0;
      rden        = 1'b0;
      wr_addr_lo  = '0;
      wr_addr_hi  = '0;
      rd_addr_lo  = '0;
      rd_addr_hi  = '0;
      wr_data_lo  = '0;
      wr_data_hi  = '0;

      apply_reset();
      compare_outputs('0, '0, "outputs after power-on reset");

      aligned_round_trip();
      misaligned_access();
      bank_wrap();
      back_to_back_reads();
      hold_and_reset();

      $display("Summary: %0d checks, %0d passed, %0d failed",
               check_count, check_count - fail_count, fail_count);
      if (fail_count == 0 && check_count > 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// File: dccm_mem.f
+incdir+include
source/dccm_pkg.sv
source/dccm_bank_if.sv
source/dccm_bank_decode.sv
source/dccm_bank_ram.sv
source/dccm_read_mux.sv
source/dccm_mem.sv
test/tb_dccm_mem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the DCCM testbench with Verilator, runs it and looks for the pass line
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module tb_dccm_mem \
   -f dccm_mem.f \
   -o sim_dccm_mem

sim_output=$(./obj_dir/sim_dccm_mem)
echo "$sim_output"

if echo "$sim_output" | grep -Fqx "All checks passed"; then
   echo "Simulation run: PASS"
   exit 0
else
   echo "Simulation run: FAIL"
   exit 1
fi
